// File: source/controlPkg.sv
`default_nettype none

package controlPkg;

    //**************************************************************************
    // widths
    parameter int INSTR_WIDTH    = 16;
    parameter int VECTOR_WIDTH   = 16;
    parameter int NUM_INTERRUPTS = 4;

    // opcode nibble, instr[3:0]
    parameter logic [3:0] OP_ALU_IMM_FIRST = 4'b0001;
    parameter logic [3:0] OP_ALU_IMM_LAST  = 4'b0111;
    parameter logic [3:0] OP_IO_IN         = 4'b1000;
    parameter logic [3:0] OP_IO_OUT        = 4'b1001;
    parameter logic [3:0] OP_REG_REG       = 4'b1010;
    parameter logic [3:0] OP_BRANCH        = 4'b1110;
    parameter logic [3:0] OP_EXTENDED      = 4'b1111;

    // sub-opcode nibble, instr[7:4]
    parameter logic [3:0] REG_REG_LAST     = 4'h9;
    parameter logic [3:0] EXT_JUMP_REG     = 4'h1;  // absolute branch through register
    parameter logic [3:0] EXT_LONG_JUMP    = 4'h2;  // address in following word
    parameter logic [3:0] EXT_SINGLE_FIRST = 4'hA;  // single-register ALU ops start here

    parameter logic [3:0] ALU_PASS_B        = 4'h1;  // LDI and MOV, no flag update
    parameter logic [3:0] STACK_POINTER_REG = 4'b1110;

    parameter logic [INSTR_WIDTH-1:0] NOP_WORD  = '0;
    parameter logic [INSTR_WIDTH-1:0] HALT_WORD = '1;

    //**************************************************************************
    // enums
    typedef enum logic [2:0] {
        part1,
        part2,          // second cycle of IN
        jumpTarget,     // fetch long jump target word
        interruptPush,  // push pc high and vector
        start           // post-reset wait
    } ctrlState_t;

    typedef enum logic [2:0] {
        aluImm, aluReg, ioAccess, branch, longJump, nop, halt, illegal
    } instrClass_t;

    typedef enum logic [2:0] {
        pcOut           = 3'd0,
        pcPlusOne       = 3'd1,
        interruptVector = 3'd2,
        instructionWord = 3'd3,
        absoluteTarget  = 3'd4,
        relativeTarget  = 3'd6
    } iMemAddrSel_t;

    typedef enum logic [2:0] {
        aluOut = 3'd0,
        pcHigh = 3'd3,
        pcLow  = 3'd4
    } dMemDataSel_t;

    typedef enum logic [1:0] {
        regFileOutB, immediate4, immediate8
    } aluSrcBSel_t;

    //**************************************************************************
    // structs
    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
    } statusFlags_t;

    typedef struct packed {
        logic         regFileSrc;          // 0 alu, 1 data memory
        logic [3:0]   regFileOutBSelect;
        logic         regFileWriteEnable;
        logic         regFileAdd;
        logic [1:0]   regFileConstSrc;
        logic         aluSrcASelect;
        aluSrcBSel_t  aluSrcBSelect;
        logic [3:0]   aluMode;
        dMemDataSel_t dMemDataSelect;
        logic [1:0]   dMemIOAddressSelect;
        logic         dMemIOWriteEn;
        logic         dMemIOReadEn;
        logic [1:0]   statusRegSrcSelect;
        logic         flagEnable;
        iMemAddrSel_t iMemAddrSelect;
        logic         iMemReadEnable;
        logic         pcWriteEn;
    } controlWord_t;

    typedef struct packed {
        instrClass_t instrClass;
        logic        condition;       // branch condition met
        logic        isOut;
        logic [3:0]  aluMode;
        logic        flagWrite;
        logic [3:0]  regSelect;
        logic        branchAbsolute;
    } decodedInstr_t;

endpackage

`default_nettype wire

// File: source/instructionDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder (
    input  logic [controlPkg::INSTR_WIDTH-1:0] instr,
    input  controlPkg::statusFlags_t           flags,
    output controlPkg::decodedInstr_t          decoded,
    output logic                               uninterruptible
);

    logic [3:0] opcode;
    logic [3:0] subcode;
    logic [3:0] aluMode;
    logic       isAluImm;
    logic       isIo;
    logic       isRegReg;
    logic       isSingleReg;
    logic       isBranch;
    logic       isJumpReg;
    logic       isLongJump;
    logic       conditionMet;

    assign opcode  = instr[3:0];
    assign subcode = instr[7:4];

    //**************************************************************************
    // format detection
    assign isAluImm    = opcode >= controlPkg::OP_ALU_IMM_FIRST
                         && opcode <= controlPkg::OP_ALU_IMM_LAST;
    assign isIo        = opcode == controlPkg::OP_IO_IN || opcode == controlPkg::OP_IO_OUT;
    assign isRegReg    = opcode == controlPkg::OP_REG_REG && subcode != 4'h0
                         && subcode <= controlPkg::REG_REG_LAST;
    assign isSingleReg = opcode == controlPkg::OP_EXTENDED
                         && subcode >= controlPkg::EXT_SINGLE_FIRST
                         && instr[11:8] == 4'h0;
    assign isBranch    = opcode == controlPkg::OP_BRANCH;
    assign isJumpReg   = opcode == controlPkg::OP_EXTENDED
                         && subcode == controlPkg::EXT_JUMP_REG && !instr[8] && !instr[12];
    assign isLongJump  = opcode == controlPkg::OP_EXTENDED
                         && subcode == controlPkg::EXT_LONG_JUMP && instr[12:8] == 5'd0;

    // condition field in the top three bits
    always_comb begin
        case (instr[15:13])
            3'b001:  conditionMet = flags.carry;
            3'b010:  conditionMet = !flags.carry;
            3'b011:  conditionMet = flags.zero;
            3'b100:  conditionMet = !flags.zero;
            3'b101:  conditionMet = flags.negative;
            3'b110:  conditionMet = !flags.negative;
            default: conditionMet = 1'b1;  // 000 and 111 always
        endcase
    end

    // immediate form carries its mode in the opcode
    assign aluMode = isAluImm ? {1'b0, instr[2:0]} : subcode;

    always_comb begin
        if (instr == controlPkg::HALT_WORD) begin
            decoded.instrClass = controlPkg::halt;
        end else if (instr == controlPkg::NOP_WORD) begin
            decoded.instrClass = controlPkg::nop;
        end else if (isAluImm) begin
            decoded.instrClass = controlPkg::aluImm;
        end else if (isIo) begin
            decoded.instrClass = controlPkg::ioAccess;
        end else if (isRegReg || isSingleReg) begin
            decoded.instrClass = controlPkg::aluReg;
        end else if (isBranch || isJumpReg) begin
            decoded.instrClass = controlPkg::branch;
        end else if (isLongJump) begin
            decoded.instrClass = controlPkg::longJump;
        end else begin
            decoded.instrClass = controlPkg::illegal;
        end
        decoded.condition      = conditionMet;
        decoded.isOut          = instr[0];
        decoded.aluMode        = aluMode;
        decoded.flagWrite      = aluMode != controlPkg::ALU_PASS_B;  // LDI, MOV keep flags
        decoded.regSelect      = instr[11:8];
        decoded.branchAbsolute = instr[0];                  // register jump has bit 0 set
    end

    assign uninterruptible = decoded.instrClass == controlPkg::halt;

endmodule

`default_nettype wire

// File: source/interruptArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module interruptArbiter #(
    parameter int vectorBase   = 20,
    parameter int vectorStride = 10
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [controlPkg::NUM_INTERRUPTS-1:0] interruptLines,
    input  logic                                  interruptAck,
    output logic                                  interruptPending,
    output logic [controlPkg::VECTOR_WIDTH-1:0]   interruptVector,
    output logic [controlPkg::NUM_INTERRUPTS-1:0] interruptClear
);

    localparam int selWidth = $clog2(controlPkg::NUM_INTERRUPTS);

    logic [selWidth-1:0] selected;
    logic                clearArmed;

    // lowest index wins
    always_comb begin
        selected = '0;
        for (int i = controlPkg::NUM_INTERRUPTS - 1; i >= 0; i--) begin
            if (interruptLines[i]) begin
                selected = i[selWidth-1:0];
            end
        end
    end

    assign interruptPending = |interruptLines;

    assign interruptVector = interruptPending
        ? controlPkg::VECTOR_WIDTH'(vectorBase + vectorStride * int'(selected))
        : '0;

    // held off until the first cycle out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            clearArmed <= 1'b0;
        end else begin
            clearArmed <= 1'b1;
        end
    end

    assign interruptClear = (interruptAck && clearArmed && interruptPending)
        ? controlPkg::NUM_INTERRUPTS'(1) << selected
        : '0;

endmodule

`default_nettype wire

// File: source/controlSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module controlSequencer #(
    parameter int startDelay = 40
) (
    input  logic                      clk,
    input  logic                      reset,
    input  controlPkg::decodedInstr_t decoded,
    input  logic                      uninterruptible,
    input  logic                      interruptEnable,
    input  logic                      interruptPending,
    output controlPkg::controlWord_t  control,
    output logic                      interruptAck,
    output logic                      resetOut
);

    localparam int countWidth = $clog2(startDelay + 2);

    controlPkg::ctrlState_t state;
    controlPkg::ctrlState_t nextState;
    logic [countWidth-1:0]  startCount;
    logic                   startDone;
    logic                   takeInterrupt;
    logic                   advance;

    //**************************************************************************
    // state and start counter
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= controlPkg::start;
            startCount <= '0;
        end else begin
            state <= nextState;
            if (state == controlPkg::start) begin
                startCount <= startCount + 1'b1;
            end else begin
                startCount <= '0;
            end
        end
    end

    assign startDone     = startCount == countWidth'(startDelay);
    assign takeInterrupt = state == controlPkg::part1 && interruptEnable
                           && interruptPending && !uninterruptible;
    assign interruptAck  = state == controlPkg::interruptPush;
    assign resetOut      = state == controlPkg::start;

    //**************************************************************************
    // control word
    always_comb begin
        control                   = '0;
        control.regFileOutBSelect = decoded.regSelect;
        control.aluSrcBSelect     = controlPkg::regFileOutB;
        control.dMemDataSelect    = controlPkg::aluOut;
        control.iMemAddrSelect    = controlPkg::pcOut;
        nextState                 = controlPkg::part1;
        advance                   = 1'b0;

        case (state)
            controlPkg::part1: begin
                if (takeInterrupt) begin
                    control.regFileOutBSelect  = controlPkg::STACK_POINTER_REG;
                    control.regFileAdd         = 1'b1;
                    control.regFileConstSrc    = 2'b01;   // sp - 1
                    control.dMemDataSelect     = controlPkg::pcLow;
                    control.dMemIOWriteEn      = 1'b1;
                    control.statusRegSrcSelect = 2'b11;   // mask interrupts
                    control.flagEnable         = 1'b1;
                    control.iMemAddrSelect     = controlPkg::interruptVector;
                    nextState                  = controlPkg::interruptPush;
                end else begin
                    case (decoded.instrClass)
                        controlPkg::aluImm: begin
                            control.regFileWriteEnable = 1'b1;
                            control.aluSrcBSelect      = controlPkg::immediate8;
                            control.aluMode            = decoded.aluMode;
                            control.flagEnable         = decoded.flagWrite;
                            advance                    = 1'b1;
                        end
                        controlPkg::aluReg: begin
                            control.regFileWriteEnable = 1'b1;
                            control.aluMode            = decoded.aluMode;
                            control.flagEnable         = decoded.flagWrite;
                            advance                    = 1'b1;
                        end
                        controlPkg::ioAccess: begin
                            control.regFileSrc          = 1'b1;
                            control.dMemIOAddressSelect = 2'b01;  // port from instr[11:4]
                            control.dMemIOWriteEn       = decoded.isOut;
                            control.dMemIOReadEn        = !decoded.isOut;
                            advance                     = decoded.isOut;
                            nextState = decoded.isOut ? controlPkg::part1 : controlPkg::part2;
                        end
                        controlPkg::branch: begin
                            if (decoded.condition) begin
                                control.iMemAddrSelect = decoded.branchAbsolute
                                    ? controlPkg::absoluteTarget
                                    : controlPkg::relativeTarget;
                            end
                            advance = 1'b1;
                        end
                        controlPkg::longJump: begin
                            // taken: step onto the target word first
                            control.iMemAddrSelect = decoded.condition
                                ? controlPkg::pcOut
                                : controlPkg::pcPlusOne;
                            advance   = 1'b1;
                            nextState = decoded.condition
                                ? controlPkg::jumpTarget
                                : controlPkg::part1;
                        end
                        controlPkg::halt: begin
                            advance = 1'b0;                  // fetch stalls here
                        end
                        default: begin
                            advance = 1'b1;                  // nop and unknown words
                        end
                    endcase
                end
            end
            controlPkg::part2: begin
                control.regFileSrc          = 1'b1;
                control.regFileWriteEnable  = 1'b1;          // IN data lands now
                control.dMemIOAddressSelect = 2'b01;
                advance                     = 1'b1;
            end
            controlPkg::jumpTarget: begin
                control.iMemAddrSelect = controlPkg::instructionWord;
                advance                = 1'b1;
            end
            controlPkg::interruptPush: begin
                control.regFileOutBSelect  = controlPkg::STACK_POINTER_REG;
                control.regFileAdd         = 1'b1;
                control.regFileConstSrc    = 2'b01;
                control.dMemDataSelect     = controlPkg::pcHigh;
                control.dMemIOWriteEn      = 1'b1;
                control.statusRegSrcSelect = 2'b11;
                control.flagEnable         = 1'b1;
                control.iMemAddrSelect     = controlPkg::interruptVector;
                advance                    = 1'b1;
            end
            controlPkg::start: begin
                control.statusRegSrcSelect = 2'b11;          // come up masked
                control.flagEnable         = 1'b1;
                control.iMemReadEnable     = 1'b1;
                advance                    = startDone;
                nextState = startDone ? controlPkg::part1 : controlPkg::start;
            end
            default: begin
                nextState = controlPkg::part1;
            end
        endcase

        control.pcWriteEn = advance;
        if (advance) begin
            control.iMemReadEnable = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit #(
    parameter int startDelay   = 40,
    parameter int vectorBase   = 20,
    parameter int vectorStride = 10
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [controlPkg::INSTR_WIDTH-1:0]    iMemOut,
    input  controlPkg::statusFlags_t              flags,
    input  logic                                  interruptEnable,
    input  logic [controlPkg::NUM_INTERRUPTS-1:0] interruptLines,
    output controlPkg::controlWord_t              control,
    output logic [controlPkg::VECTOR_WIDTH-1:0]   interruptVector,
    output logic [controlPkg::NUM_INTERRUPTS-1:0] interruptClear,
    output logic                                  resetOut
);

    controlPkg::decodedInstr_t decoded;
    logic                      uninterruptible;
    logic                      interruptPending;
    logic                      interruptAck;

    instructionDecoder decoder (
        .instr           (iMemOut),
        .flags           (flags),
        .decoded         (decoded),
        .uninterruptible (uninterruptible)
    );

    interruptArbiter #(
        .vectorBase   (vectorBase),
        .vectorStride (vectorStride)
    ) arbiter (
        .clk              (clk),
        .reset            (reset),
        .interruptLines   (interruptLines),
        .interruptAck     (interruptAck),
        .interruptPending (interruptPending),
        .interruptVector  (interruptVector),
        .interruptClear   (interruptClear)
    );

    controlSequencer #(
        .startDelay (startDelay)
    ) sequencer (
        .clk              (clk),
        .reset            (reset),
        .decoded          (decoded),
        .uninterruptible  (uninterruptible),
        .interruptEnable  (interruptEnable),
        .interruptPending (interruptPending),
        .control          (control),
        .interruptAck     (interruptAck),
        .resetOut         (resetOut)
    );

endmodule

`default_nettype wire

// File: tests/controlUnit_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit_assertions (
    input logic                                  clk,
    input logic                                  reset,
    input controlPkg::controlWord_t              control,
    input logic [controlPkg::NUM_INTERRUPTS-1:0] interruptLines,
    input logic [controlPkg::NUM_INTERRUPTS-1:0] interruptClear
);

    int   failures = 0;  // failed assertion tally
    logic pushStart;
    logic [controlPkg::NUM_INTERRUPTS-1:0] lowestPending;

    // first push cycle of an interrupt entry
    assign pushStart = control.dMemIOWriteEn && control.dMemDataSelect == controlPkg::pcLow;

    // lowest set bit of the pending lines
    assign lowestPending = interruptLines
        & ~(interruptLines - controlPkg::NUM_INTERRUPTS'(1));

    clearOneHot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(interruptClear)
        && (interruptClear == '0 || interruptClear == lowestPending))
    else begin
        failures++;
        $error("interrupt clear is not zero or the highest-priority pending line");
    end

    clearAfterEntry: assert property (@(posedge clk) disable iff (reset)
        interruptClear != '0 |-> $past(pushStart))
    else begin
        failures++;
        $error("interrupt clear outside the second cycle of an interrupt entry");
    end

    ioStrobesExclusive: assert property (@(posedge clk) disable iff (reset)
        !(control.dMemIOWriteEn && control.dMemIOReadEn))
    else begin
        failures++;
        $error("IO read and write strobes high together");
    end

endmodule

bind controlUnit controlUnit_assertions checks (
    .clk            (clk),
    .reset          (reset),
    .control        (control),
    .interruptLines (interruptLines),
    .interruptClear (interruptClear)
);

`default_nettype wire

// File: tests/controlUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;

    localparam int clkPeriod   = 4;
    localparam int resetCycles = 8;
    localparam int startDelay  = 8;
    // reset, start wait, alu, io, branch, interrupt
    localparam int testCycles  = resetCycles + (startDelay + 2) + 22 + 3 + 32 + 6;
    localparam logic [15:0] expectedVector = 16'(20 + 10 * 2);  // line 2 serviced

    logic                     clk;
    logic                     reset;
    logic [15:0]              iMemOut;
    controlPkg::statusFlags_t flags;
    logic                     interruptEnable;
    logic [3:0]               interruptLines;
    controlPkg::controlWord_t control;
    logic [15:0]              interruptVector;
    logic [3:0]               interruptClear;
    logic                     resetOut;

    logic [31:0] lfsrState  = 32'h7403;
    int          checkCount = 0;
    int          errorCount = 0;

    controlUnit #(.startDelay(startDelay)) DUT (
        .clk             (clk),
        .reset           (reset),
        .iMemOut         (iMemOut),
        .flags           (flags),
        .interruptEnable (interruptEnable),
        .interruptLines  (interruptLines),
        .control         (control),
        .interruptVector (interruptVector),
        .interruptClear  (interruptClear),
        .resetOut        (resetOut)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    //**************************************************************************
    // helpers
    function automatic logic [31:0] lfsrNext(input logic [31:0] value);
        return value[0] ? (value >> 1) ^ 32'h80200003 : value >> 1;  // galois form
    endfunction

    task automatic randomBits(input int count, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value     = {value[14:0], lfsrState[0]};  // one step per bit
        end
    endtask

    // flag bits are carry, zero, negative from msb down
    function automatic logic conditionHolds(input logic [2:0] cond, input logic [2:0] f);
        case (cond)
            3'd1:    return f[2];
            3'd2:    return !f[2];
            3'd3:    return f[1];
            3'd4:    return !f[1];
            3'd5:    return f[0];
            3'd6:    return !f[0];
            default: return 1'b1;
        endcase
    endfunction

    task automatic checkBit(input string name, input logic got, input logic expected);
        checkCount++;
        assert (got === expected) else begin
            errorCount++;
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, expected);
        end
    endtask

    task automatic checkValue(input string name, input logic [15:0] got,
                              input logic [15:0] expected);
        checkCount++;
        assert (got === expected) else begin
            errorCount++;
            $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got,
                     expected);
        end
    endtask

    // drives one cycle and samples outputs 1 ns after the falling edge
    task automatic driveCycle(input logic [15:0] word, input logic [2:0] flagBits,
                              input logic irqEnable = 1'b0, input logic [3:0] irqLines = '0);
        @(negedge clk);
        iMemOut         = word;
        flags           = flagBits;
        interruptEnable = irqEnable;
        interruptLines  = irqLines;
        #1;
    endtask

    task automatic checkAluCycle(input logic [15:0] word, input logic [3:0] mode,
                                 input logic immForm);
        driveCycle(word, 3'b000);
        checkBit("regFileWriteEnable", control.regFileWriteEnable, 1'b1);
        checkValue("aluMode", 16'(control.aluMode), 16'(mode));
        checkValue("aluSrcBSelect", 16'(control.aluSrcBSelect),
                   immForm ? 16'(controlPkg::immediate8) : 16'(controlPkg::regFileOutB));
        checkBit("flagEnable", control.flagEnable, mode != 4'd1);  // LDI, MOV keep flags
        checkBit("pcWriteEn", control.pcWriteEn, 1'b1);
    endtask

    //**************************************************************************
    // directed tests
    task automatic testStartWait();
        for (int i = 0; i <= startDelay; i++) begin
            checkBit("resetOut", resetOut, 1'b1);
            checkBit("pcWriteEn", control.pcWriteEn, i == startDelay);
            checkBit("regFileWriteEnable", control.regFileWriteEnable, 1'b0);
            checkBit("dMemIOWriteEn", control.dMemIOWriteEn, 1'b0);
            checkBit("dMemIOReadEn", control.dMemIOReadEn, 1'b0);
            checkValue("interruptClear", 16'(interruptClear), 16'h0);
            @(negedge clk);
            if (i == startDelay) begin
                interruptEnable = 1'b0;  // first part1 cycle runs a plain NOP
                interruptLines  = '0;
            end
            #1;
        end
        checkBit("resetOut", resetOut, 1'b0);  // first part1 cycle
    endtask

    task automatic testAlu();
        logic [15:0] bits;
        for (int op = 1; op <= 7; op++) begin
            randomBits(12, bits);
            checkAluCycle({bits[11:0], 4'(op)}, 4'(op), 1'b1);
        end
        for (int sub = 1; sub <= 9; sub++) begin
            randomBits(8, bits);
            checkAluCycle({bits[7:0], 4'(sub), 4'b1010}, 4'(sub), 1'b0);
        end
        for (int sub = 10; sub <= 15; sub++) begin
            randomBits(4, bits);
            checkAluCycle({bits[3:0], 4'h0, 4'(sub), 4'hF}, 4'(sub), 1'b0);  // single reg
        end
    endtask

    task automatic testIo();
        logic [15:0] bits;
        randomBits(12, bits);
        driveCycle({bits[11:0], 4'b1001}, 3'b000);  // OUT
        checkBit("dMemIOWriteEn", control.dMemIOWriteEn, 1'b1);
        checkBit("dMemIOReadEn", control.dMemIOReadEn, 1'b0);
        checkBit("pcWriteEn", control.pcWriteEn, 1'b1);
        randomBits(12, bits);
        driveCycle({bits[11:0], 4'b1000}, 3'b000);  // IN read cycle
        checkBit("dMemIOReadEn", control.dMemIOReadEn, 1'b1);
        checkBit("regFileWriteEnable", control.regFileWriteEnable, 1'b0);
        checkBit("pcWriteEn", control.pcWriteEn, 1'b0);
        driveCycle(controlPkg::NOP_WORD, 3'b000);   // IN write-back cycle
        checkBit("dMemIOReadEn", control.dMemIOReadEn, 1'b0);
        checkBit("regFileWriteEnable", control.regFileWriteEnable, 1'b1);
        checkBit("pcWriteEn", control.pcWriteEn, 1'b1);
    endtask

    task automatic testBranches();
        logic [15:0] bits;
        logic [15:0] f;
        logic        taken;
        for (int cond = 0; cond < 8; cond++) begin
            randomBits(3, f);
            randomBits(9, bits);
            taken = conditionHolds(3'(cond), f[2:0]);
            driveCycle({3'(cond), bits[8:0], 4'b1110}, f[2:0]);  // relative
            checkValue("iMemAddrSelect", 16'(control.iMemAddrSelect), taken
                       ? 16'(controlPkg::relativeTarget) : 16'(controlPkg::pcOut));
            checkBit("pcWriteEn", control.pcWriteEn, 1'b1);

            randomBits(3, f);
            randomBits(3, bits);
            taken = conditionHolds(3'(cond), f[2:0]);
            driveCycle({3'(cond), 1'b0, bits[2:0], 1'b0, 4'h1, 4'hF}, f[2:0]);  // absolute
            checkValue("iMemAddrSelect", 16'(control.iMemAddrSelect), taken
                       ? 16'(controlPkg::absoluteTarget) : 16'(controlPkg::pcOut));
            checkBit("pcWriteEn", control.pcWriteEn, 1'b1);

            randomBits(3, f);
            taken = conditionHolds(3'(cond), f[2:0]);
            driveCycle({3'(cond), 5'd0, 4'h2, 4'hF}, f[2:0]);  // long jump
            checkBit("pcWriteEn", control.pcWriteEn, 1'b1);
            if (taken) begin
                checkValue("iMemAddrSelect", 16'(control.iMemAddrSelect),
                           16'(controlPkg::pcOut));
                randomBits(16, bits);
                driveCycle(bits, f[2:0]);  // target word
                checkValue("iMemAddrSelect", 16'(control.iMemAddrSelect),
                           16'(controlPkg::instructionWord));
                checkBit("pcWriteEn", control.pcWriteEn, 1'b1);
            end else begin
                checkValue("iMemAddrSelect", 16'(control.iMemAddrSelect),
                           16'(controlPkg::pcPlusOne));
            end
        end
    endtask

    task automatic testInterrupts();
        driveCycle(controlPkg::NOP_WORD, 3'b000, 1'b1, 4'b1100);
        checkValue("dMemDataSelect", 16'(control.dMemDataSelect), 16'(controlPkg::pcLow));
        checkBit("dMemIOWriteEn", control.dMemIOWriteEn, 1'b1);
        checkBit("flagEnable", control.flagEnable, 1'b1);
        checkValue("interruptClear", 16'(interruptClear), 16'h0);
        driveCycle(controlPkg::NOP_WORD, 3'b000, 1'b1, 4'b1100);
        checkValue("dMemDataSelect", 16'(control.dMemDataSelect), 16'(controlPkg::pcHigh));
        checkBit("dMemIOWriteEn", control.dMemIOWriteEn, 1'b1);
        checkValue("interruptClear", 16'(interruptClear), 16'b0100);
        checkValue("interruptVector", interruptVector, expectedVector);

        driveCycle(controlPkg::NOP_WORD, 3'b000, 1'b0, 4'b1100);  // masked so a plain NOP
        checkBit("pcWriteEn", control.pcWriteEn, 1'b1);
        checkBit("dMemIOWriteEn", control.dMemIOWriteEn, 1'b0);
        checkValue("interruptClear", 16'(interruptClear), 16'h0);
        repeat (3) begin
            driveCycle(controlPkg::HALT_WORD, 3'b000, 1'b1, 4'b1100);  // HLT holds
            checkBit("pcWriteEn", control.pcWriteEn, 1'b0);
            checkBit("dMemIOWriteEn", control.dMemIOWriteEn, 1'b0);
            checkValue("interruptClear", 16'(interruptClear), 16'h0);
        end
    endtask

    //**************************************************************************
    // main sequence and watchdog
    initial begin
        reset           = 1'b1;
        iMemOut         = controlPkg::NOP_WORD;
        flags           = '0;
        interruptEnable = 1'b0;
        interruptLines  = '0;
        repeat (resetCycles) @(negedge clk);
        reset           = 1'b0;
        interruptEnable = 1'b1;     // pending line held through the start wait
        interruptLines  = 4'b0001;
        #1;
        testStartWait();
        testAlu();
        testIo();
        testBranches();
        testInterrupts();
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checkCount, errorCount, DUT.checks.failures);
        if (errorCount == 0 && DUT.checks.failures == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(testCycles * clkPeriod * 2);
        $display("watchdog expired before the tests completed");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
source/controlPkg.sv
source/instructionDecoder.sv
source/interruptArbiter.sv
source/controlSequencer.sv
source/controlUnit.sv
tests/controlUnit_assertions.sv
tests/controlUnitTb.sv

// File: Makefile
TOP := controlUnitTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
